// File: src/i_cache_defs.svh
//----------------------------------------
// i-cache parameters
// address fields, line geometry and
// transaction queue depth
//----------------------------------------
`ifndef I_CACHE_DEFS_SVH
`define I_CACHE_DEFS_SVH

`define I_CACHE_ADDR_W        16
`define I_CACHE_NUM_TQ_ENTRY  4
`define I_CACHE_NUM_SETS      16
`define I_CACHE_WORDS_IN_CL   4
`define I_CACHE_REG_ID_W      5

`define I_CACHE_WORD_W        32
`define I_CACHE_CL_W          (`I_CACHE_WORDS_IN_CL * `I_CACHE_WORD_W)
`define I_CACHE_TQ_ID_W       $clog2(`I_CACHE_NUM_TQ_ENTRY)

//----------------------------------------
// address fields
//----------------------------------------
// bits 1:0 are the byte offset, always zero for instruction fetch
`define LSB_WORD_OFFSET       2
`define MSB_WORD_OFFSET       3
`define LSB_SET               4
`define MSB_SET               7
`define LSB_TAG               8
`define MSB_TAG               15

`endif

// File: src/i_cache_pkg.sv
//----------------------------------------
// i-cache types
// vector widths, entry states and
// lookup kinds shared by queue and pipe
//----------------------------------------
`include "i_cache_defs.svh"

package i_cache_pkg;

    typedef logic [`I_CACHE_ADDR_W-1:0]                t_address;
    typedef logic [`I_CACHE_WORD_W-1:0]                t_word;
    typedef logic [`I_CACHE_CL_W-1:0]                  t_cl;
    typedef logic [`MSB_TAG-`LSB_SET:0]                t_cl_address; // tag and set
    typedef logic [`MSB_SET-`LSB_SET:0]                t_set;
    typedef logic [`MSB_TAG-`LSB_TAG:0]                t_tag;
    typedef logic [`MSB_WORD_OFFSET-`LSB_WORD_OFFSET:0] t_word_offset;
    typedef logic [`I_CACHE_REG_ID_W-1:0]              t_reg_id;
    typedef logic [`I_CACHE_TQ_ID_W-1:0]               t_tq_id;

    // transaction queue entry
    typedef enum logic [1:0] {
        S_IDLE,
        S_LU_CORE,          // core read in the pipe
        S_MB_WAIT_FILL,     // waiting for far memory
        S_MB_FILL_READY     // line in merge buffer, waiting for a pipe slot
    } t_tq_state;

    typedef enum logic [1:0] {
        NO_LU,
        RD_LU,
        FILL_LU
    } t_lu_op;

    typedef enum logic [1:0] {
        HIT,
        MISS,
        FILL
    } t_lu_result;

endpackage

// File: src/i_cache_tq.sv
//----------------------------------------
// i-cache transaction queue
// tracks reads in flight, holds missed lines
// in merge buffers, issues fill lookups and
// answers the core in order
//----------------------------------------
`timescale 1ns/1ps
`include "i_cache_defs.svh"

module i_cache_tq (
    input  logic                    clk,
    input  logic                    arst_n,
    // core
    input  logic                    req_valid,
    input  i_cache_pkg::t_address   req_address,
    input  i_cache_pkg::t_reg_id    req_reg_id,
    output logic                    ready,
    output logic                    rsp_valid,
    output i_cache_pkg::t_word      rsp_data,
    output i_cache_pkg::t_address   rsp_address,
    output i_cache_pkg::t_reg_id    rsp_reg_id,
    // pipe q1
    output logic                    lu_req_valid,
    output i_cache_pkg::t_lu_op     lu_req_op,
    output i_cache_pkg::t_address   lu_req_address,
    output i_cache_pkg::t_tq_id     lu_req_tq_id,
    output i_cache_pkg::t_reg_id    lu_req_reg_id,
    output logic                    lu_req_rd_indication,
    output i_cache_pkg::t_cl        lu_req_cl_data,
    // pipe q2
    input  logic                    early_rd_miss,
    input  logic                    early_fill_valid,
    input  i_cache_pkg::t_tq_id     early_fill_tq_id,
    // pipe q3
    input  logic                    lu_rsp_valid,
    input  i_cache_pkg::t_lu_op     lu_rsp_op,
    input  i_cache_pkg::t_lu_result lu_rsp_result,
    input  i_cache_pkg::t_tq_id     lu_rsp_tq_id,
    input  i_cache_pkg::t_address   lu_rsp_address,
    input  i_cache_pkg::t_reg_id    lu_rsp_reg_id,
    input  logic                    lu_rsp_rd_indication,
    input  i_cache_pkg::t_cl        lu_rsp_cl_data,
    // far memory
    input  logic                    fm_rd_rsp_valid,
    input  i_cache_pkg::t_tq_id     fm_rd_rsp_tq_id,
    input  i_cache_pkg::t_cl        fm_rd_rsp_data
);

    localparam int NUM_ENTRY = `I_CACHE_NUM_TQ_ENTRY;

    i_cache_pkg::t_tq_state    tq_state       [NUM_ENTRY];
    i_cache_pkg::t_cl_address  tq_cl_address  [NUM_ENTRY];
    i_cache_pkg::t_word_offset tq_word_offset [NUM_ENTRY];
    i_cache_pkg::t_reg_id      tq_reg_id      [NUM_ENTRY];
    i_cache_pkg::t_cl          tq_mb          [NUM_ENTRY];   // merge buffers
    logic [NUM_ENTRY-1:0]      tq_rd_ind;

    logic [NUM_ENTRY-1:0]      alloc;
    logic [NUM_ENTRY-1:0]      fm_load;
    logic [$clog2(NUM_ENTRY+1)-1:0] idle_cnt;
    i_cache_pkg::t_tq_id       free_id;
    i_cache_pkg::t_tq_id       fill_id;
    i_cache_pkg::t_tq_id       miss_tq_id;
    logic                      fill_exists;
    logic                      take;
    logic                      fill_sel;
    logic                      rd_q3;
    logic                      stall_q;
    logic                      miss_filled;
    logic                      stall_clr;

    //----------------------------------------
    // entry search, lowest index wins
    //----------------------------------------
    always_comb begin
        free_id     = '0;
        fill_id     = '0;
        fill_exists = 1'b0;
        idle_cnt    = '0;
        for (int i = NUM_ENTRY - 1; i >= 0; i--) begin
            if (tq_state[i] == i_cache_pkg::S_IDLE) begin
                free_id  = i_cache_pkg::t_tq_id'(i);
                idle_cnt = idle_cnt + 1'b1;
            end
            if (tq_state[i] == i_cache_pkg::S_MB_FILL_READY) begin
                fill_id     = i_cache_pkg::t_tq_id'(i);
                fill_exists = 1'b1;
            end
        end
    end

    // keep two idle entries so a request never finds the queue full
    assign ready    = (idle_cnt >= 2) && !stall_q && !early_rd_miss;
    assign take     = req_valid && ready;
    assign fill_sel = fill_exists && !take;     // fills only use empty slots
    assign rd_q3    = lu_rsp_valid && (lu_rsp_op == i_cache_pkg::RD_LU);

    always_comb begin
        for (int i = 0; i < NUM_ENTRY; i++) begin
            alloc[i]   = take && (free_id == i);
            fm_load[i] = fm_rd_rsp_valid && (fm_rd_rsp_tq_id == i) &&
                         (tq_state[i] == i_cache_pkg::S_MB_WAIT_FILL);
        end
    end

    //----------------------------------------
    // entry state machines
    //----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_ENTRY; i++) begin
                tq_state[i] <= i_cache_pkg::S_IDLE;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRY; i++) begin
                case (tq_state[i])
                    i_cache_pkg::S_IDLE: begin
                        if (alloc[i]) begin
                            tq_state[i] <= i_cache_pkg::S_LU_CORE;
                        end
                    end
                    i_cache_pkg::S_LU_CORE: begin
                        if (rd_q3 && (lu_rsp_tq_id == i)) begin
                            tq_state[i] <= (lu_rsp_result == i_cache_pkg::HIT) ?
                                           i_cache_pkg::S_IDLE : i_cache_pkg::S_MB_WAIT_FILL;
                        end
                    end
                    i_cache_pkg::S_MB_WAIT_FILL: begin
                        if (fm_load[i]) begin
                            tq_state[i] <= i_cache_pkg::S_MB_FILL_READY;
                        end
                    end
                    default: begin          // fill ready
                        if (fill_sel && (fill_id == i)) begin
                            tq_state[i] <= i_cache_pkg::S_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRY; i++) begin
            if (alloc[i]) begin
                tq_cl_address[i]  <= req_address[`MSB_TAG:`LSB_SET];
                tq_word_offset[i] <= req_address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET];
                tq_reg_id[i]      <= req_reg_id;
                tq_rd_ind[i]      <= 1'b1;
            end
            if (fm_load[i]) begin
                tq_mb[i] <= fm_rd_rsp_data;
            end
        end
        if (rd_q3 && (lu_rsp_result == i_cache_pkg::MISS)) begin
            miss_tq_id <= lu_rsp_tq_id;
        end
    end

    //----------------------------------------
    // miss stall
    //----------------------------------------
    // held from the q2 miss until the cycle after its fill leaves q3
    assign stall_clr = miss_filled && !fill_exists;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_q     <= 1'b0;
            miss_filled <= 1'b0;
        end else if (early_rd_miss) begin
            stall_q <= 1'b1;
        end else if (stall_clr) begin
            stall_q     <= 1'b0;
            miss_filled <= 1'b0;
        end else if (stall_q && early_fill_valid && (early_fill_tq_id == miss_tq_id)) begin
            miss_filled <= 1'b1;
        end
    end

    //----------------------------------------
    // q1 lookup mux, core first
    //----------------------------------------
    always_comb begin
        lu_req_valid         = 1'b0;
        lu_req_op            = i_cache_pkg::NO_LU;
        lu_req_address       = '0;
        lu_req_tq_id         = '0;
        lu_req_reg_id        = '0;
        lu_req_rd_indication = 1'b0;
        lu_req_cl_data       = '0;
        if (take) begin
            lu_req_valid         = 1'b1;
            lu_req_op            = i_cache_pkg::RD_LU;
            lu_req_address       = req_address;
            lu_req_tq_id         = free_id;
            lu_req_reg_id        = req_reg_id;
            lu_req_rd_indication = 1'b1;
        end else if (fill_exists) begin
            lu_req_valid         = 1'b1;
            lu_req_op            = i_cache_pkg::FILL_LU;
            lu_req_address       = {tq_cl_address[fill_id], tq_word_offset[fill_id], 2'b00};
            lu_req_tq_id         = fill_id;
            lu_req_reg_id        = tq_reg_id[fill_id];
            lu_req_rd_indication = tq_rd_ind[fill_id];
            lu_req_cl_data       = tq_mb[fill_id];
        end
    end

    // core response from q3: a read hit or a fill that carries the read
    assign rsp_valid   = (rd_q3 && (lu_rsp_result == i_cache_pkg::HIT)) ||
                         (lu_rsp_valid && (lu_rsp_op == i_cache_pkg::FILL_LU) &&
                          lu_rsp_rd_indication);
    assign rsp_data    = lu_rsp_cl_data[`I_CACHE_WORD_W *
                         lu_rsp_address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET] +: `I_CACHE_WORD_W];
    assign rsp_address = lu_rsp_address;
    assign rsp_reg_id  = lu_rsp_reg_id;

    a_fm_rsp_to_waiting: assert property (@(posedge clk) disable iff (!arst_n)
        fm_rd_rsp_valid |-> (tq_state[fm_rd_rsp_tq_id] == i_cache_pkg::S_MB_WAIT_FILL));

    a_no_req_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> ready);

endmodule

// File: src/i_cache_pipe.sv
//----------------------------------------
// i-cache lookup pipe
// direct-mapped tag and data arrays, tag
// compare in q2, array access at q2 -> q3,
// far-memory request on a q3 miss
//----------------------------------------
`timescale 1ns/1ps
`include "i_cache_defs.svh"

module i_cache_pipe (
    input  logic                    clk,
    input  logic                    arst_n,
    // q1 from the queue
    input  logic                    lu_req_valid,
    input  i_cache_pkg::t_lu_op     lu_req_op,
    input  i_cache_pkg::t_address   lu_req_address,
    input  i_cache_pkg::t_tq_id     lu_req_tq_id,
    input  i_cache_pkg::t_reg_id    lu_req_reg_id,
    input  logic                    lu_req_rd_indication,
    input  i_cache_pkg::t_cl        lu_req_cl_data,
    // q2 early response
    output logic                    early_rd_miss,
    output logic                    early_fill_valid,
    output i_cache_pkg::t_tq_id     early_fill_tq_id,
    // q3 final response
    output logic                    lu_rsp_valid,
    output i_cache_pkg::t_lu_op     lu_rsp_op,
    output i_cache_pkg::t_lu_result lu_rsp_result,
    output i_cache_pkg::t_tq_id     lu_rsp_tq_id,
    output i_cache_pkg::t_address   lu_rsp_address,
    output i_cache_pkg::t_reg_id    lu_rsp_reg_id,
    output logic                    lu_rsp_rd_indication,
    output i_cache_pkg::t_cl        lu_rsp_cl_data,
    // far memory
    output logic                    fm_rd_req_valid,
    output i_cache_pkg::t_tq_id     fm_rd_req_tq_id,
    output i_cache_pkg::t_cl_address fm_rd_req_cl_address
);

    logic [`I_CACHE_NUM_SETS-1:0] set_valid;
    i_cache_pkg::t_tag            tag_array  [`I_CACHE_NUM_SETS];
    i_cache_pkg::t_cl             data_array [`I_CACHE_NUM_SETS];

    logic                         q2_valid;
    i_cache_pkg::t_lu_op          q2_op;
    i_cache_pkg::t_address        q2_address;
    i_cache_pkg::t_tq_id          q2_tq_id;
    i_cache_pkg::t_reg_id         q2_reg_id;
    logic                         q2_rd_indication;
    i_cache_pkg::t_cl             q2_cl_data;

    i_cache_pkg::t_set            q2_set;
    i_cache_pkg::t_tag            q2_tag;
    logic                         q2_hit;
    logic                         q2_fill;

    //----------------------------------------
    // q2 tag compare
    //----------------------------------------
    assign q2_set  = q2_address[`MSB_SET:`LSB_SET];
    assign q2_tag  = q2_address[`MSB_TAG:`LSB_TAG];
    assign q2_hit  = set_valid[q2_set] && (tag_array[q2_set] == q2_tag);
    assign q2_fill = q2_valid && (q2_op == i_cache_pkg::FILL_LU);

    assign early_rd_miss    = q2_valid && (q2_op == i_cache_pkg::RD_LU) && !q2_hit;
    assign early_fill_valid = q2_fill;
    assign early_fill_tq_id = q2_tq_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q2_valid     <= 1'b0;
            lu_rsp_valid <= 1'b0;
            set_valid    <= '0;
        end else begin
            q2_valid     <= lu_req_valid;
            lu_rsp_valid <= q2_valid;
            if (q2_fill) begin
                set_valid[q2_set] <= 1'b1;
            end
        end
    end

    //----------------------------------------
    // stage payload and array access
    //----------------------------------------
    always_ff @(posedge clk) begin
        q2_op            <= lu_req_op;
        q2_address       <= lu_req_address;
        q2_tq_id         <= lu_req_tq_id;
        q2_reg_id        <= lu_req_reg_id;
        q2_rd_indication <= lu_req_rd_indication;
        q2_cl_data       <= lu_req_cl_data;

        lu_rsp_op            <= q2_op;
        lu_rsp_tq_id         <= q2_tq_id;
        lu_rsp_address       <= q2_address;
        lu_rsp_reg_id        <= q2_reg_id;
        lu_rsp_rd_indication <= q2_rd_indication;
        if (q2_fill) begin
            lu_rsp_result  <= i_cache_pkg::FILL;
            lu_rsp_cl_data <= q2_cl_data;       // merged line goes back as is
            tag_array[q2_set]  <= q2_tag;
            data_array[q2_set] <= q2_cl_data;
        end else begin
            lu_rsp_result  <= q2_hit ? i_cache_pkg::HIT : i_cache_pkg::MISS;
            lu_rsp_cl_data <= data_array[q2_set];
        end
    end

    // one-cycle far-memory request while the miss sits in q3
    assign fm_rd_req_valid      = lu_rsp_valid && (lu_rsp_op == i_cache_pkg::RD_LU) &&
                                  (lu_rsp_result == i_cache_pkg::MISS);
    assign fm_rd_req_tq_id      = lu_rsp_tq_id;
    assign fm_rd_req_cl_address = lu_rsp_address[`MSB_TAG:`LSB_SET];

    // the miss stall keeps reads of the set out of the pipe ahead of its fill
    a_fill_after_read: assert property (@(posedge clk) disable iff (!arst_n)
        q2_fill |-> !(lu_rsp_valid && (lu_rsp_op == i_cache_pkg::RD_LU) &&
                      (lu_rsp_address[`MSB_SET:`LSB_SET] == q2_set)));

endmodule

// File: src/i_cache_top.sv
//----------------------------------------
// i-cache top
// transaction queue and lookup pipe
//----------------------------------------
`timescale 1ns/1ps

module i_cache_top (
    input  logic                     clk,
    input  logic                     arst_n,
    // core
    input  logic                     req_valid,
    input  i_cache_pkg::t_address    req_address,
    input  i_cache_pkg::t_reg_id     req_reg_id,
    output logic                     ready,
    output logic                     rsp_valid,
    output i_cache_pkg::t_word       rsp_data,
    output i_cache_pkg::t_address    rsp_address,
    output i_cache_pkg::t_reg_id     rsp_reg_id,
    // far memory
    output logic                     fm_rd_req_valid,
    output i_cache_pkg::t_tq_id      fm_rd_req_tq_id,
    output i_cache_pkg::t_cl_address fm_rd_req_cl_address,
    input  logic                     fm_rd_rsp_valid,
    input  i_cache_pkg::t_tq_id      fm_rd_rsp_tq_id,
    input  i_cache_pkg::t_cl         fm_rd_rsp_data
);

    // queue to pipe, q1
    logic                    lu_req_valid;
    i_cache_pkg::t_lu_op     lu_req_op;
    i_cache_pkg::t_address   lu_req_address;
    i_cache_pkg::t_tq_id     lu_req_tq_id;
    i_cache_pkg::t_reg_id    lu_req_reg_id;
    logic                    lu_req_rd_indication;
    i_cache_pkg::t_cl        lu_req_cl_data;

    // pipe to queue, q2 and q3
    logic                    early_rd_miss;
    logic                    early_fill_valid;
    i_cache_pkg::t_tq_id     early_fill_tq_id;
    logic                    lu_rsp_valid;
    i_cache_pkg::t_lu_op     lu_rsp_op;
    i_cache_pkg::t_lu_result lu_rsp_result;
    i_cache_pkg::t_tq_id     lu_rsp_tq_id;
    i_cache_pkg::t_address   lu_rsp_address;
    i_cache_pkg::t_reg_id    lu_rsp_reg_id;
    logic                    lu_rsp_rd_indication;
    i_cache_pkg::t_cl        lu_rsp_cl_data;

    i_cache_tq u_tq (.*);

    i_cache_pipe u_pipe (.*);

endmodule

// File: verification/i_cache_tb.sv
//----------------------------------------
// i-cache testbench
// reads request vectors, models far memory
// and checks every core response in order
//----------------------------------------
`timescale 1ns/1ps
`include "i_cache_defs.svh"

module i_cache_tb;

    localparam string VECTOR_FILE   = "verification/i_cache_vectors.txt";
    localparam int    READY_TIMEOUT = 200;
    localparam int    DRAIN_TIMEOUT = 400;

    typedef struct packed {
        logic [15:0] address;
        logic [4:0]  reg_id;
        logic        hit;
        logic [31:0] data;
        logic [31:0] accept_edge;
        logic [1:0]  tq_id;
    } exp_rsp_t;

    logic                            clk;
    logic                            arst_n;
    logic                            req_valid;
    i_cache_pkg::t_address           req_address;
    i_cache_pkg::t_reg_id            req_reg_id;
    logic                            ready;
    logic                            rsp_valid;
    i_cache_pkg::t_word              rsp_data;
    i_cache_pkg::t_address           rsp_address;
    i_cache_pkg::t_reg_id            rsp_reg_id;
    logic                            fm_rd_req_valid;
    i_cache_pkg::t_tq_id             fm_rd_req_tq_id;
    i_cache_pkg::t_cl_address        fm_rd_req_cl_address;
    logic                            fm_rd_rsp_valid;
    i_cache_pkg::t_tq_id             fm_rd_rsp_tq_id;
    i_cache_pkg::t_cl                fm_rd_rsp_data;

    exp_rsp_t    sb_q[$];            // expected responses in request order
    logic [11:0] miss_q[$];          // line addresses of expected misses
    logic [1:0]  miss_id_q[$];       // queue entries of expected misses
    logic [1:0]  fm_id_q[$];
    logic [11:0] fm_line_q[$];
    int          fm_due_q[$];
    int          free_at [4];        // first acceptance edge an entry is idle again
    exp_rsp_t    got;
    int          cycle;
    int          seed = 32'h4ecc;
    int          fm_delay;
    logic        miss_pending;
    logic        prev_hit;

    i_cache_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //----------------------------------------
    // failure reporting and checking
    //----------------------------------------
    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("ERROR: %s", reason);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // word w of line L is {A5, L, w}
    function automatic logic [31:0] rule_word(input logic [11:0] cl_addr,
                                              input logic [11:0] w);
        return {8'hA5, cl_addr, w};
    endfunction

    function automatic logic [127:0] rule_line(input logic [11:0] cl_addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = rule_word(cl_addr, 12'(w));
        end
        return line;
    endfunction

    //----------------------------------------
    // request driver
    //----------------------------------------
    task automatic drive_request(input logic [15:0] addr, input int reg_id,
                                 input int gap, input int hit);
        int       waited;
        exp_rsp_t e;
        @(negedge clk);
        req_valid = 1'b0;
        repeat (gap) @(negedge clk);
        waited = 0;
        while (!ready) begin
            if (waited >= READY_TIMEOUT) begin
                report_failure("ready stayed low while waiting to send a request");
            end
            @(negedge clk);
            waited++;
        end
        if (gap == 0 && prev_hit) begin
            check_value("back_to_back_accept_wait", 0, waited);   // no stall after a hit
        end
        req_valid   = 1'b1;
        req_address = addr;
        req_reg_id  = reg_id[4:0];
        e.address     = addr;
        e.reg_id      = reg_id[4:0];
        e.hit         = (hit != 0);
        e.data        = rule_word(addr[`MSB_TAG:`LSB_SET],
                                  {10'b0, addr[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]});
        e.accept_edge = cycle + 1;                                  // taken at next posedge
        e.tq_id       = 2'd0;
        for (int i = 3; i >= 0; i--) begin                          // lowest idle entry
            if (free_at[i] <= e.accept_edge) begin
                e.tq_id = 2'(i);
            end
        end
        sb_q.push_back(e);
        if (hit == 0) begin
            miss_q.push_back(addr[`MSB_TAG:`LSB_SET]);
            miss_id_q.push_back(e.tq_id);
            free_at[e.tq_id] = 32'h7fff_ffff;                       // busy until its fill
        end else begin
            free_at[e.tq_id] = e.accept_edge + 3;                   // idle after leaving q3
        end
        prev_hit = (hit != 0);
    endtask

    //----------------------------------------
    // far-memory responder
    //----------------------------------------
    initial begin
        fm_rd_rsp_valid = 1'b0;
        fm_rd_rsp_tq_id = '0;
        fm_rd_rsp_data  = '0;
        forever begin
            @(negedge clk);
            fm_rd_rsp_valid = 1'b0;
            if (fm_due_q.size() > 0 && cycle >= fm_due_q[0]) begin
                fm_rd_rsp_valid = 1'b1;
                fm_rd_rsp_tq_id = fm_id_q.pop_front();
                fm_rd_rsp_data  = rule_line(fm_line_q.pop_front());
                void'(fm_due_q.pop_front());
            end
        end
    end

    //----------------------------------------
    // response monitor and scoreboard
    //----------------------------------------
    always @(negedge clk) begin
        if (arst_n) begin
            if (miss_pending) begin
                check_value("ready_low_during_miss", 0, ready);
            end
            if (fm_rd_req_valid) begin
                if (miss_q.size() == 0) begin
                    report_failure("far-memory request issued for a read expected to hit");
                end
                check_value("fm_cl_address", miss_q.pop_front(), fm_rd_req_cl_address);
                check_value("fm_tq_id", miss_id_q.pop_front(), fm_rd_req_tq_id);
                fm_delay = 2 + ($unsigned($random(seed)) % 8);
                fm_id_q.push_back(fm_rd_req_tq_id);
                fm_line_q.push_back(fm_rd_req_cl_address);
                fm_due_q.push_back(cycle + fm_delay);
                miss_pending = 1'b1;
            end
            if (rsp_valid) begin
                if (sb_q.size() == 0) begin
                    report_failure("core response seen with no request outstanding");
                end
                got = sb_q.pop_front();
                check_value("rsp_data", got.data, rsp_data);
                check_value("rsp_address", got.address, rsp_address);
                check_value("rsp_reg_id", got.reg_id, rsp_reg_id);
                if (got.hit) begin
                    check_value("hit_latency_edge", got.accept_edge + 2, cycle + 1);
                end else begin
                    check_value("miss_slower_than_hit", 1, (cycle + 1) > (got.accept_edge + 2));
                    miss_pending     = 1'b0;
                    free_at[got.tq_id] = 0;
                end
            end
        end
    end

    //----------------------------------------
    // main sequence
    //----------------------------------------
    initial begin
        int          fd;
        int          n_read;
        int          reg_id;
        int          gap;
        int          hit;
        int          n_vec;
        int          waited;
        logic [15:0] addr;
        string       line;

        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_address  = '0;
        req_reg_id   = '0;
        miss_pending = 1'b0;
        prev_hit     = 1'b0;
        n_vec        = 0;
        for (int i = 0; i < 4; i++) begin
            free_at[i] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (5) begin                            // idle after reset
            @(negedge clk);
            check_value("idle_ready", 1, ready);
            check_value("idle_rsp_valid", 0, rsp_valid);
            check_value("idle_fm_req_valid", 0, fm_rd_req_valid);
        end

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            report_failure("cannot open the request vector file");
        end
        while (!$feof(fd)) begin
            line   = "";
            n_read = $fgets(line, fd);
            if (n_read > 0 && line.getc(0) != 8'h23) begin      // skip # lines
                if ($sscanf(line, "%h %d %d %d", addr, reg_id, gap, hit) == 4) begin
                    drive_request(addr, reg_id, gap, hit);
                    n_vec++;
                end
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            report_failure("no request vectors were read");
        end

        @(negedge clk);
        req_valid = 1'b0;
        waited    = 0;
        while (sb_q.size() > 0) begin               // drain outstanding responses
            if (waited >= DRAIN_TIMEOUT) begin
                report_failure("responses still missing at the end of the run");
            end
            @(negedge clk);
            waited++;
        end
        check_value("unissued_misses", 0, miss_q.size());
        repeat (4) @(negedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/i_cache_vectors.txt
# address(hex) reg_id(dec) idle_gap_cycles(dec) expect_hit(1=hit 0=miss)
# set = addr[7:4], tag = addr[15:8], word = addr[3:2]
1200 1 0 0
1204 2 0 1
1208 3 0 1
120C 4 0 1
1210 5 3 0
121C 6 0 1
1214 7 1 1
1218 8 0 1
3400 9 2 0
3408 10 0 1
1200 11 0 0
1208 12 0 1
3404 13 1 0
340C 14 0 1
56F0 15 0 0
56FC 16 0 1
56F4 17 0 1
56F8 18 5 1
ABC4 19 0 0
ABC0 20 0 1
1210 21 0 1
12CC 22 2 0
ABC8 23 0 0
12C8 24 0 0
1214 25 0 1
3400 26 0 1
0020 0 0 0
002C 31 0 1

// File: flist.f
+incdir+src
src/i_cache_pkg.sv
src/i_cache_tq.sv
src/i_cache_pipe.sv
src/i_cache_top.sv
verification/i_cache_tb.sv

// File: Makefile
# Verilator build and run for the i-cache testbench

VERILATOR   ?= verilator
TOP         ?= i_cache_tb
RTL_TOP     ?= i_cache_top
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_MSG    ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
